//--- all.f
design/ctrl_pkg.sv
design/phase_decoder.sv
design/cmem_read_gen.sv
design/gbus_write_gen.sv
design/core_ctrl.sv
bench/core_ctrl_checker.sv
bench/core_ctrl_tb.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := core_ctrl_tb
FILELIST := all.f
BUILD    := obj_dir

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD)

//--- bench/core_ctrl_tb.sv
`timescale 1ns/1ns

module core_ctrl_tb;
	import ctrl_pkg::*;

	localparam int NUM_PHASES  = 20;
	localparam int CYCLE_LIMIT = 200 * NUM_PHASES;

	logic        clk;
	logic        rst_n;
	phase_t      phase;
	logic        phase_update;
	logic        start;
	logic [7:0]  head_words;
	logic [9:0]  proj_words;
	logic        hlink_wen;
	logic [7:0]  quant_data;
	logic        quant_valid;
	logic [24:0] rc_data;
	logic        rc_valid;
	logic        cmem_ren;
	logic [12:0] cmem_raddr;
	logic        gbus_wen;
	logic [18:0] gbus_addr;
	logic [31:0] gbus_wdata;
	logic        finish;
	logic        recompute_needed;

	logic [31:0] rng;
	int          cycles;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          i;

	core_ctrl #(.CORE_INDEX(4'd3)) core_ctrl_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic logic [12:0] weight_base(logic [3:0] code);
		case (code)
			4'd2:    return 13'd128;
			4'd3:    return 13'd256;
			4'd6:    return 13'd384;
			4'd7:    return 13'd512;
			4'd8:    return 13'd1024;
			default: return 13'd0;
		endcase
	endfunction

	function automatic logic [3:0] code_for_run(int n);
		case (n % 6)
			0:       return 4'd1;
			1:       return 4'd2;
			2:       return 4'd3;
			3:       return 4'd6;
			4:       return 4'd7;
			default: return 4'd8;
		endcase
	endfunction

	task automatic report_mismatch(string test, string what, logic [31:0] exp, logic [31:0] act);
		$display("** Error: %s: %s expected 'h%0h, actual 'h%0h", test, what, exp, act);
		errors++;
	endtask

	task automatic close_test(string test);
		tests_run++;
		if (errors == 0) begin
			$display("test %s passed", test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d mismatches", test, errors);
		end
		errors = 0;
	endtask

	// every code 0..8 is loaded with host-link writes running, so codes 4 and 5 must not read.
	task automatic recompute_test();
		int   code;
		logic exp_flag;
		logic exp_read;

		for (code = 0; code < 9; code++) begin
			@(posedge clk);
			phase        <= phase_t'(4'(code));
			phase_update <= 1'b1;
			hlink_wen    <= 1'b1;
			@(posedge clk);
			phase_update <= 1'b0;
			@(posedge clk);
			@(negedge clk);
			exp_flag = (code >= 1 && code <= 3) || code == 7;
			exp_read = (code >= 1 && code <= 3) || (code >= 6 && code <= 8);
			if (recompute_needed !== exp_flag) begin
				report_mismatch("recompute", "recompute_needed", 32'(exp_flag), 32'(recompute_needed));
			end
			if (cmem_ren !== exp_read) begin
				report_mismatch("recompute", "cmem_ren", 32'(exp_read), 32'(cmem_ren));
			end
		end
		close_test("recompute");
	endtask

	task automatic run_phase(int idx, logic [3:0] code);
		string       name;
		logic [31:0] r;
		logic [7:0]  hw;
		logic [9:0]  pw;
		logic        global_sel;
		logic        want;
		int          limit;
		int          offset;
		int          issued;
		int          written;
		logic        exp_ren;
		logic [12:0] exp_raddr;
		logic        exp_wen;
		logic [31:0] exp_wdata;
		logic [1:0]  exp_sel;
		logic [3:0]  lane_start;
		logic [3:0]  exp_lane;
		logic [4:0]  exp_row;
		logic        exp_finish;
		logic        next_finish;
		logic        after_finish;
		logic        done;
		logic        exp_flag;

		name       = $sformatf("run%0d_phase%0d", idx, code);
		hw         = 8'(next_random() % 8 + 1);
		pw         = 10'(16 * (next_random() % 8 + 1));
		global_sel = (code == 4'd6) || (code == 4'd8);
		case (code)
			4'd7:       limit = 4 * hw;
			4'd6, 4'd8: limit = pw / 16;
			default:    limit = hw;
		endcase
		offset       = 3 * limit; // core 3 sits behind three slices of the same width.
		lane_start   = 4'(offset % 16);
		exp_lane     = lane_start;
		exp_row      = 5'(offset / 16);
		exp_sel      = global_sel ? 2'd2 : 2'd1;
		exp_raddr    = weight_base(code);
		exp_ren      = 1'b0;
		exp_wen      = 1'b0;
		exp_wdata    = '0;
		exp_finish   = 1'b0;
		after_finish = 1'b0;
		done         = 1'b0;
		issued       = 0;
		written      = 0;

		@(posedge clk);
		phase        <= phase_t'(code);
		phase_update <= 1'b1;
		head_words   <= hw;
		proj_words   <= pw;
		hlink_wen    <= 1'b0;
		quant_valid  <= 1'b0;
		rc_valid     <= 1'b0;
		@(posedge clk);
		phase_update <= 1'b0;
		start        <= 1'b1;
		@(posedge clk);
		start        <= 1'b0;
		@(negedge clk);
		exp_flag = (code >= 1 && code <= 3) || code == 7;
		if (recompute_needed !== exp_flag) begin
			report_mismatch(name, "recompute_needed", 32'(exp_flag), 32'(recompute_needed));
		end

		while (!done) begin
			@(posedge clk);
			r    = next_random();
			want = r[1] && (issued < limit); // stop feeding once the phase has all its outputs.
			if (want) begin
				issued++;
			end
			hlink_wen   <= r[0] && !after_finish;
			quant_valid <= global_sel ? (r[2] && !after_finish) : want;
			rc_valid    <= global_sel ? want : (r[2] && !after_finish);
			quant_data  <= r[15:8];
			rc_data     <= r[31:7];
			@(negedge clk);
			if (cmem_ren !== exp_ren) begin
				report_mismatch(name, "cmem_ren", 32'(exp_ren), 32'(cmem_ren));
			end
			if (cmem_raddr !== exp_raddr) begin
				report_mismatch(name, "cmem_raddr", 32'(exp_raddr), 32'(cmem_raddr));
			end
			if (gbus_wen !== exp_wen) begin
				report_mismatch(name, "gbus_wen", 32'(exp_wen), 32'(gbus_wen));
			end
			if (exp_wen && gbus_addr !== {exp_sel, 8'h00, exp_lane, exp_row}) begin
				report_mismatch(name, "gbus_addr", 32'({exp_sel, 8'h00, exp_lane, exp_row}),
					32'(gbus_addr));
			end
			if (exp_wen && gbus_wdata !== exp_wdata) begin
				report_mismatch(name, "gbus_wdata", exp_wdata, gbus_wdata);
			end
			if (finish !== exp_finish) begin
				report_mismatch(name, "finish", 32'(exp_finish), 32'(finish));
			end
			if (exp_finish && gbus_addr !== 19'd0) begin
				report_mismatch(name, "cleared gbus_addr", 32'd0, 32'(gbus_addr));
			end

			if (after_finish) begin
				done = 1'b1;
			end else begin
				after_finish = exp_finish;
				if (exp_finish) begin
					exp_raddr = '0;
				end else if (exp_ren) begin
					exp_raddr = exp_raddr + 1'b1;
				end
				exp_ren     = hlink_wen && !exp_finish;
				next_finish = 1'b0;
				if (exp_wen && !exp_finish) begin
					written++;
					if (written == limit) begin
						next_finish = 1'b1;
					end else if (written % 16 == 0) begin
						exp_row  = exp_row + 1'b1; // a full row of lanes is done.
						exp_lane = lane_start;
					end else begin
						exp_lane = exp_lane + 1'b1;
					end
				end
				exp_wen = (global_sel ? rc_valid : quant_valid) && !exp_finish;
				if (exp_wen) begin
					exp_wdata = global_sel ? {7'd0, rc_data} : {24'd0, quant_data};
				end
				exp_finish = next_finish;
			end
		end
		close_test(name);
	endtask

	initial begin
		rng          = 32'hc547a8cf;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n        <= 1'b0;
		phase        <= PH_IDLE;
		phase_update <= 1'b0;
		start        <= 1'b0;
		head_words   <= '0;
		proj_words   <= '0;
		hlink_wen    <= 1'b0;
		quant_data   <= '0;
		quant_valid  <= 1'b0;
		rc_data      <= '0;
		rc_valid     <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		recompute_test();
		for (i = 0; i < NUM_PHASES; i++) begin
			run_phase(i, code_for_run(i)); // phases run back to back.
		end

		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles, finish never came", cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- bench/core_ctrl_checker.sv
`timescale 1ns/1ns

module core_ctrl_checker (
	input logic             clk,
	input logic             rst_n,
	input ctrl_pkg::phase_t cur_phase,
	input logic             cmem_ren,
	input logic             gbus_wen,
	input logic             finish
);
	import ctrl_pkg::*;

	logic idle;

	// unsupported codes count as idle too.
	assign idle = !(cur_phase inside {PH_Q, PH_K, PH_V, PH_PROJ, PH_FFN0, PH_FFN1});

	finish_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) finish |=> !finish)
		else $error("finish stayed high for two cycles");

	no_write_after_finish: assert property (@(posedge clk) disable iff (!rst_n)
		finish |=> !gbus_wen)
		else $error("gbus_wen high in the cycle after finish");

	// cmem_ren is registered, so it follows the phase one cycle later.
	no_read_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$past(idle) |-> !cmem_ren)
		else $error("cmem_ren high while the phase is idle");

endmodule

bind core_ctrl core_ctrl_checker core_ctrl_checker_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.cur_phase (cur_phase),
	.cmem_ren  (cmem_ren),
	.gbus_wen  (gbus_wen),
	.finish    (finish)
);

//--- design/core_ctrl.sv
`timescale 1ns/1ns

module core_ctrl #(
	parameter logic [ctrl_pkg::CORE_W-1:0] CORE_INDEX = '0
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  ctrl_pkg::phase_t                    phase,
	input  logic                                phase_update,
	input  logic                                start,
	input  logic [ctrl_pkg::CFG_HEAD_W-1:0]     head_words,
	input  logic [ctrl_pkg::CFG_PROJ_W-1:0]     proj_words,
	input  logic                                hlink_wen,
	input  logic [ctrl_pkg::QUANT_W-1:0]        quant_data,
	input  logic                                quant_valid,
	input  logic [ctrl_pkg::RC_W-1:0]           rc_data,
	input  logic                                rc_valid,
	output logic                                cmem_ren,
	output logic [ctrl_pkg::CMEM_ADDR_W-1:0]    cmem_raddr,
	output logic                                gbus_wen,
	output logic [ctrl_pkg::GBUS_ADDR_W-1:0]    gbus_addr,
	output logic [ctrl_pkg::GBUS_DATA_W-1:0]    gbus_wdata,
	output logic                                finish,
	output logic                                recompute_needed
);
	import ctrl_pkg::*;

	phase_t              cur_phase;
	logic                start_q;
	logic [OP_CNT_W-1:0] op_limit;

	phase_decoder phase_decoder_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.phase            (phase),
		.phase_update     (phase_update),
		.start            (start),
		.head_words       (head_words),
		.proj_words       (proj_words),
		.cur_phase        (cur_phase),
		.start_q          (start_q),
		.op_limit         (op_limit),
		.recompute_needed (recompute_needed)
	);

	// reads stop on the finish raised by the write side.
	cmem_read_gen cmem_read_gen_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cur_phase  (cur_phase),
		.start_q    (start_q),
		.finish     (finish),
		.hlink_wen  (hlink_wen),
		.cmem_ren   (cmem_ren),
		.cmem_raddr (cmem_raddr)
	);

	gbus_write_gen #(
		.CORE_INDEX (CORE_INDEX)
	) gbus_write_gen_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.cur_phase   (cur_phase),
		.start_q     (start_q),
		.op_limit    (op_limit),
		.head_words  (head_words),
		.proj_words  (proj_words),
		.quant_data  (quant_data),
		.quant_valid (quant_valid),
		.rc_data     (rc_data),
		.rc_valid    (rc_valid),
		.gbus_wen    (gbus_wen),
		.gbus_addr   (gbus_addr),
		.gbus_wdata  (gbus_wdata),
		.finish      (finish)
	);

endmodule

//--- design/gbus_write_gen.sv
`timescale 1ns/1ns

module gbus_write_gen #(
	parameter logic [ctrl_pkg::CORE_W-1:0] CORE_INDEX = '0
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  ctrl_pkg::phase_t                    cur_phase,
	input  logic                                start_q,
	input  logic [ctrl_pkg::OP_CNT_W-1:0]       op_limit,
	input  logic [ctrl_pkg::CFG_HEAD_W-1:0]     head_words,
	input  logic [ctrl_pkg::CFG_PROJ_W-1:0]     proj_words,
	input  logic [ctrl_pkg::QUANT_W-1:0]        quant_data,
	input  logic                                quant_valid,
	input  logic [ctrl_pkg::RC_W-1:0]           rc_data,
	input  logic                                rc_valid,
	output logic                                gbus_wen,
	output logic [ctrl_pkg::GBUS_ADDR_W-1:0]    gbus_addr,
	output logic [ctrl_pkg::GBUS_DATA_W-1:0]    gbus_wdata,
	output logic                                finish
);
	import ctrl_pkg::*;

	localparam int OFFSET_W = CORE_W + OP_CNT_W;

	logic                   active;
	logic                   use_rc;
	logic                   src_valid;
	logic [GBUS_DATA_W-1:0] src_data;
	logic [OFFSET_W-1:0]    core_offset;
	logic [LANE_W-1:0]      lane_start;
	logic [ROW_W-1:0]       row_start;
	logic                   last_write;

	logic [BIAS_W-1:0]      mem_sel;
	logic [LANE_W-1:0]      lane;
	logic [ROW_W-1:0]       row;
	logic [OP_CNT_W-1:0]    op_cnt;

	assign active = phase_active(cur_phase);
	assign use_rc = phase_global(cur_phase); // accumulated data goes to global memory.

	always_comb begin
		if (use_rc) begin
			src_valid = rc_valid;
			src_data  = {{(GBUS_DATA_W - RC_W){1'b0}}, rc_data};
		end else begin
			src_valid = quant_valid;
			src_data  = {{(GBUS_DATA_W - QUANT_W){1'b0}}, quant_data};
		end
	end

	// this core's slice starts right after the slices of the lower cores.
	assign core_offset = CORE_INDEX * core_width(cur_phase, head_words, proj_words);
	assign lane_start  = core_offset[LANE_W-1:0];
	assign row_start   = core_offset[LANE_W +: ROW_W];

	assign last_write = gbus_wen && (op_cnt == op_limit - 1'b1);

	// local field is zero above the lane and row fields.
	assign gbus_addr = {mem_sel, {CORE_W{1'b0}},
		{(LOCAL_W - LANE_W - ROW_W){1'b0}}, lane, row};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gbus_wen   <= 1'b0;
			gbus_wdata <= '0;
		end else begin
			gbus_wen <= active && src_valid && !finish; // nothing lands after the last write.
			if (active && src_valid && !finish) begin
				gbus_wdata <= src_data;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			finish <= 1'b0;
		end else begin
			finish <= active && !finish && !start_q && last_write;
		end
	end

	// walk lanes first, then step to the next row every MAC_LANES writes.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_sel <= '0;
			lane    <= '0;
			row     <= '0;
			op_cnt  <= '0;
		end else if (finish) begin
			mem_sel <= '0;
			lane    <= '0;
			row     <= '0;
			op_cnt  <= '0;
		end else if (active && start_q) begin
			mem_sel <= use_rc ? SEL_GLOBAL_MEM : SEL_HEAD_MEM;
			lane    <= lane_start;
			row     <= row_start;
			op_cnt  <= '0;
		end else if (active && last_write) begin
			mem_sel <= '0;
			lane    <= '0;
			row     <= '0;
			op_cnt  <= '0;
		end else if (active && gbus_wen) begin
			if (op_cnt[LANE_W-1:0] == LANE_W'(MAC_LANES - 1)) begin
				row  <= row + 1'b1;
				lane <= lane_start;
			end else begin
				lane <= lane + 1'b1;
			end
			op_cnt <= op_cnt + 1'b1;
		end
	end

endmodule

//--- design/cmem_read_gen.sv
`timescale 1ns/1ns

module cmem_read_gen (
	input  logic                                clk,
	input  logic                                rst_n,
	input  ctrl_pkg::phase_t                    cur_phase,
	input  logic                                start_q,
	input  logic                                finish,
	input  logic                                hlink_wen,
	output logic                                cmem_ren,
	output logic [ctrl_pkg::CMEM_ADDR_W-1:0]    cmem_raddr
);
	import ctrl_pkg::*;

	logic                   active;
	logic [CMEM_ADDR_W-1:0] phase_base;

	assign active = phase_active(cur_phase);

	always_comb begin
		case (cur_phase)
			PH_Q:    phase_base = Q_BASE;
			PH_K:    phase_base = K_BASE;
			PH_V:    phase_base = V_BASE;
			PH_PROJ: phase_base = PROJ_BASE;
			PH_FFN0: phase_base = FFN0_BASE;
			PH_FFN1: phase_base = FFN1_BASE;
			default: phase_base = '0;
		endcase
	end

	// one weight word is fetched for every host-link write.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmem_ren <= 1'b0;
		end else begin
			cmem_ren <= active && hlink_wen && !finish;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmem_raddr <= '0;
		end else if (!active || finish) begin
			cmem_raddr <= '0; // park at zero between phases.
		end else if (start_q) begin
			cmem_raddr <= phase_base;
		end else if (cmem_ren) begin
			cmem_raddr <= cmem_raddr + 1'b1;
		end
	end

endmodule

//--- design/phase_decoder.sv
`timescale 1ns/1ns

module phase_decoder (
	input  logic                                clk,
	input  logic                                rst_n,
	input  ctrl_pkg::phase_t                    phase,
	input  logic                                phase_update,
	input  logic                                start,
	input  logic [ctrl_pkg::CFG_HEAD_W-1:0]     head_words,
	input  logic [ctrl_pkg::CFG_PROJ_W-1:0]     proj_words,
	output ctrl_pkg::phase_t                    cur_phase,
	output logic                                start_q,
	output logic [ctrl_pkg::OP_CNT_W-1:0]       op_limit,
	output logic                                recompute_needed
);
	import ctrl_pkg::*;

	// phase register, held until the host loads the next one.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_phase <= PH_IDLE;
		end else if (phase_update) begin
			cur_phase <= phase;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
		end else begin
			start_q <= start;
		end
	end

	// the limit is latched once per phase and held while the generators run.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_limit <= '0;
		end else if (start_q && phase_active(cur_phase)) begin
			op_limit <= core_width(cur_phase, head_words, proj_words);
		end
	end

	// projection results are consumed once; the others feed a later pass.
	always_comb begin
		case (cur_phase)
			PH_Q, PH_K, PH_V, PH_FFN0: recompute_needed = 1'b1;
			default:                   recompute_needed = 1'b0;
		endcase
	end

endmodule

//--- design/ctrl_pkg.sv
package ctrl_pkg;

	// layer phase codes, as the host sends them.
	typedef enum logic [3:0] {
		PH_IDLE = 4'd0,
		PH_Q    = 4'd1,
		PH_K    = 4'd2,
		PH_V    = 4'd3,
		PH_PROJ = 4'd6,
		PH_FFN0 = 4'd7,
		PH_FFN1 = 4'd8
	} phase_t;

	localparam int CMEM_ADDR_W = 13;
	localparam int GBUS_DATA_W = 32;
	localparam int QUANT_W     = 8;
	localparam int RC_W        = 25;
	localparam int OP_CNT_W    = 10;

	// configuration port widths.
	localparam int CFG_HEAD_W = 8;
	localparam int CFG_PROJ_W = 10;

	localparam int MAC_LANES = 16;
	localparam int LANE_W    = 4;
	localparam int ROW_W     = 5;
	localparam int CORE_W    = 4;
	localparam int BIAS_W    = 2;
	localparam int LOCAL_W   = 13;
	localparam int GBUS_ADDR_W = BIAS_W + CORE_W + LOCAL_W; // 19 bits.

	localparam logic [BIAS_W-1:0] SEL_HEAD_MEM   = 2'd1;
	localparam logic [BIAS_W-1:0] SEL_GLOBAL_MEM = 2'd2;

	// first weight word of each phase.
	localparam logic [CMEM_ADDR_W-1:0] Q_BASE    = 13'd0;
	localparam logic [CMEM_ADDR_W-1:0] K_BASE    = 13'd128;
	localparam logic [CMEM_ADDR_W-1:0] V_BASE    = 13'd256;
	localparam logic [CMEM_ADDR_W-1:0] PROJ_BASE = 13'd384;
	localparam logic [CMEM_ADDR_W-1:0] FFN0_BASE = 13'd512;
	localparam logic [CMEM_ADDR_W-1:0] FFN1_BASE = 13'd1024;

	// codes 4 and 5 are legal on the wire but run as idle.
	function automatic logic phase_active(phase_t p);
		return p inside {PH_Q, PH_K, PH_V, PH_PROJ, PH_FFN0, PH_FFN1};
	endfunction

	function automatic logic phase_global(phase_t p);
		return p inside {PH_PROJ, PH_FFN1};
	endfunction

	// outputs produced by one core in the given phase.
	function automatic logic [OP_CNT_W-1:0] core_width(
		phase_t                  p,
		logic [CFG_HEAD_W-1:0]   head_words,
		logic [CFG_PROJ_W-1:0]   proj_words
	);
		case (p)
			PH_Q, PH_K, PH_V:  return OP_CNT_W'(head_words);
			PH_FFN0:           return OP_CNT_W'({head_words, 2'b00});
			PH_PROJ, PH_FFN1:  return OP_CNT_W'(proj_words / MAC_LANES);
			default:           return '0;
		endcase
	endfunction

endpackage
